/* src/mems_defs.svh */
`ifndef MEMS_DEFS_SVH
`define MEMS_DEFS_SVH

// system clocks per sck period
// must be a power of two, at least 2
`define MEMS_CLK_DIV 16

// one dac frame, msb first on the wire
// 2 pad bits, 3-bit command, 3-bit address, 16-bit code
`define MEMS_FRAME_W 24

// dac outputs driving the mirror axes
`define MEMS_NUM_CH 4

// code width per output
`define MEMS_DATA_W 16

`endif

/* src/spi_pkg.sv */
package spi_pkg;

  // serializer states, one pass from idle back to idle per frame
  typedef enum logic [2:0] {
    idle,
    wait_half,  // cs_n low, frame sampled from the link
    transfer,   // one sck period per bit
    wait_cs_1,  // hold after the last bit, then cs_n high
    wait_cs_2   // cs_n high gap before completion
  } spi_state_t;

endpackage

/* src/dac_pkg.sv */
package dac_pkg;

  // command field, frame bits 21 to 19
  typedef enum logic [2:0] {
    cmd_write_input = 3'b000,  // load input register, output unchanged
    cmd_update_all  = 3'b001,  // update dac register, address 7 hits all outputs
    cmd_sw_reset    = 3'b101,  // data 0 clears all registers
    cmd_int_ref     = 3'b111   // data bit 0 enables the internal reference
  } dac_cmd_t;

  // frame sequencer states
  typedef enum logic [2:0] {
    seq_idle,
    seq_init_reset,   // issue software reset frame
    seq_init_ref,     // issue reference enable frame
    seq_send_ch,      // issue write-input frame for ch_q
    seq_send_update,  // issue update-all frame closing a burst
    seq_wait_done     // frame in flight
  } seq_state_t;

endpackage

/* src/spi_frame_if.sv */
`timescale 1ns/1ps

`include "mems_defs.svh"

// frame request from the sequencer to the serializer
interface spi_frame_if;

  logic [`MEMS_FRAME_W-1:0] frame;     // held from start until new_data
  logic                     start;     // one cycle, only while busy is low
  logic                     busy;
  logic                     new_data;  // one cycle at frame end

  modport master (
    output frame,
    output start,
    input  busy,
    input  new_data
  );

  modport slave (
    input  frame,
    input  start,
    output busy,
    output new_data
  );

endinterface

/* src/mems_spi_tx.sv */
`timescale 1ns/1ps

`include "mems_defs.svh"

module mems_spi_tx import spi_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  spi_frame_if.slave link,
  output logic       sck,
  output logic       mosi,
  output logic       cs_n
);

  localparam int div     = `MEMS_CLK_DIV;
  localparam int ctr_w   = $clog2(div);
  localparam int frame_w = `MEMS_FRAME_W;
  localparam int bit_w   = $clog2(frame_w);

  localparam logic [ctr_w-1:0] ctr_last = ctr_w'(div - 1);      // end of an sck period
  localparam logic [ctr_w-1:0] ctr_half = ctr_w'(div / 2 - 1);  // end of half a period
  localparam logic [ctr_w-1:0] ctr_mid  = ctr_w'(div / 2);
  localparam logic [bit_w-1:0] bit_last = bit_w'(frame_w - 1);

  spi_state_t         state_q, state_d;
  logic [ctr_w-1:0]   ctr_q, ctr_d;      // clock divider, wraps every sck period
  logic [bit_w-1:0]   bit_q, bit_d;      // bits already sent
  logic [frame_w-1:0] shift_q, shift_d;
  logic               mosi_q, mosi_d;
  logic               cs_n_q, cs_n_d;
  logic               new_data_q, new_data_d;

  // sck idles low, rises at the start of each bit period
  assign sck  = ~ctr_q[ctr_w-1] & (state_q == transfer);
  assign mosi = mosi_q;
  assign cs_n = cs_n_q;

  assign link.busy     = (state_q != idle);
  assign link.new_data = new_data_q;

  always_comb begin
    state_d    = state_q;
    ctr_d      = ctr_q;
    bit_d      = bit_q;
    shift_d    = shift_q;
    mosi_d     = mosi_q;
    cs_n_d     = cs_n_q;
    new_data_d = 1'b0;

    case (state_q)
      idle: begin
        ctr_d = '0;
        bit_d = '0;
        if (link.start) begin
          state_d = wait_half;
          cs_n_d  = 1'b0;
        end
      end

      wait_half: begin
        ctr_d   = ctr_q + 1'b1;
        shift_d = link.frame;
        if (ctr_q == ctr_mid) begin
          // msb goes out ahead of the first rising edge
          mosi_d  = link.frame[frame_w-1];
          shift_d = {link.frame[frame_w-2:0], 1'b0};
          ctr_d   = '0;
          state_d = transfer;
        end
      end

      transfer: begin
        ctr_d = ctr_q + 1'b1;
        if (ctr_q == ctr_last) begin
          bit_d = bit_q + 1'b1;
          if (bit_q == bit_last) begin
            mosi_d  = 1'b0;
            state_d = wait_cs_1;
          end else begin
            mosi_d  = shift_q[frame_w-1];  // changes with the rising edge
            shift_d = {shift_q[frame_w-2:0], 1'b0};
          end
        end
      end

      wait_cs_1: begin
        ctr_d = ctr_q + 1'b1;
        if (ctr_q == ctr_half) begin
          cs_n_d  = 1'b1;
          ctr_d   = '0;
          state_d = wait_cs_2;
        end
      end

      wait_cs_2: begin
        ctr_d = ctr_q + 1'b1;
        if (ctr_q == ctr_half) begin
          ctr_d      = '0;
          new_data_d = 1'b1;  // same cycle busy falls
          state_d    = idle;
        end
      end

      default: begin
        state_d = idle;
        cs_n_d  = 1'b1;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q    <= idle;
      ctr_q      <= '0;
      bit_q      <= '0;
      mosi_q     <= 1'b0;
      cs_n_q     <= 1'b1;  // dac deselected out of reset
      new_data_q <= 1'b0;
    end else begin
      state_q    <= state_d;
      ctr_q      <= ctr_d;
      bit_q      <= bit_d;
      mosi_q     <= mosi_d;
      cs_n_q     <= cs_n_d;
      new_data_q <= new_data_d;
    end
  end

  always_ff @(posedge clk) begin
    shift_q <= shift_d;
  end

endmodule

/* src/dac_frame_seq.sv */
`timescale 1ns/1ps

`include "mems_defs.svh"

module dac_frame_seq import dac_pkg::*; (
  input  logic                            clk,
  input  logic                            rst,
  input  logic [$clog2(`MEMS_NUM_CH)-1:0] ch_sel,
  input  logic [`MEMS_DATA_W-1:0]         ch_data,
  input  logic                            ch_write,
  input  logic                            commit,
  output logic                            busy,
  output logic                            init_done,
  spi_frame_if.master                     link
);

  localparam int num_ch  = `MEMS_NUM_CH;
  localparam int ch_w    = $clog2(num_ch);
  localparam int data_w  = `MEMS_DATA_W;
  localparam int pad_w   = `MEMS_FRAME_W - 6 - data_w;
  localparam int cmd_lsb = data_w + 3;

  localparam logic [2:0] addr_all = 3'd7;

  seq_state_t               state_q, state_d;
  logic [data_w-1:0]        shadow_q [num_ch];  // last code written per channel
  logic [num_ch-1:0]        dirty_q;            // written since its last frame
  logic                     pending_q, pending_d;
  logic                     init_done_q, init_done_d;
  logic [ch_w-1:0]          ch_q, ch_d;
  logic [`MEMS_FRAME_W-1:0] frame_q, frame_next;
  logic                     issue;
  logic                     burst_go;
  logic                     first_found, next_found;
  logic [ch_w-1:0]          first_ch, next_ch;
  dac_cmd_t                 sent_cmd;

  // one cycle per frame in the issue states
  assign issue    = state_q inside {seq_init_reset, seq_init_ref, seq_send_ch, seq_send_update};
  assign burst_go = commit | pending_q;
  assign sent_cmd = dac_cmd_t'(frame_q[cmd_lsb +: 3]);  // frame in flight

  assign link.start = issue;
  assign link.frame = issue ? frame_next : frame_q;

  assign busy      = (state_q != seq_idle) | link.busy;
  assign init_done = init_done_q;

  // lowest dirty channel, and lowest dirty channel above ch_q
  always_comb begin
    first_found = 1'b0;
    first_ch    = '0;
    next_found  = 1'b0;
    next_ch     = '0;
    for (int i = num_ch - 1; i >= 0; i--) begin
      if (dirty_q[i]) begin
        first_found = 1'b1;
        first_ch    = ch_w'(i);
      end
      if (dirty_q[i] && (ch_w'(i) > ch_q)) begin
        next_found = 1'b1;
        next_ch    = ch_w'(i);
      end
    end
  end

  always_comb begin
    case (state_q)
      seq_init_reset: frame_next = {pad_w'(0), cmd_sw_reset, 3'd0, data_w'(0)};
      seq_init_ref:   frame_next = {pad_w'(0), cmd_int_ref, 3'd0, data_w'(1)};
      seq_send_ch:    frame_next = {pad_w'(0), cmd_write_input, 3'(ch_q), shadow_q[ch_q]};
      default:        frame_next = {pad_w'(0), cmd_update_all, addr_all, data_w'(0)};
    endcase
  end

  always_comb begin
    state_d     = state_q;
    ch_d        = ch_q;
    pending_d   = pending_q | commit;  // further commits merge
    init_done_d = init_done_q;

    case (state_q)
      seq_idle: begin
        if (!init_done_q) begin
          state_d = seq_init_reset;
        end else if (burst_go) begin
          pending_d = 1'b0;
          ch_d      = first_ch;
          state_d   = first_found ? seq_send_ch : seq_send_update;
        end
      end

      seq_init_reset, seq_init_ref, seq_send_ch, seq_send_update: begin
        state_d = seq_wait_done;
      end

      seq_wait_done: begin
        if (link.new_data) begin
          case (sent_cmd)
            cmd_sw_reset: state_d = seq_init_ref;
            cmd_int_ref: begin
              init_done_d = 1'b1;
              state_d     = seq_idle;
            end
            cmd_write_input: begin
              ch_d    = next_ch;
              state_d = next_found ? seq_send_ch : seq_send_update;
            end
            default: begin
              // burst over, a held commit starts the next one right away
              if (burst_go) begin
                pending_d = 1'b0;
                ch_d      = first_ch;
                state_d   = first_found ? seq_send_ch : seq_send_update;
              end else begin
                state_d = seq_idle;
              end
            end
          endcase
        end
      end

      default: state_d = seq_idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q     <= seq_idle;
      pending_q   <= 1'b0;
      init_done_q <= 1'b0;
      ch_q        <= '0;
    end else begin
      state_q     <= state_d;
      pending_q   <= pending_d;
      init_done_q <= init_done_d;
      ch_q        <= ch_d;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      dirty_q <= '0;
    end else begin
      if (state_q == seq_send_ch) dirty_q[ch_q] <= 1'b0;  // value taken at start
      if (ch_write) dirty_q[ch_sel] <= 1'b1;  // a write in the same cycle wins
    end
  end

  always_ff @(posedge clk) begin
    if (ch_write) shadow_q[ch_sel] <= ch_data;
    if (issue) frame_q <= frame_next;
  end

endmodule

/* src/mems_dac_top.sv */
`timescale 1ns/1ps

`include "mems_defs.svh"

module mems_dac_top (
  input  logic                            clk,
  input  logic                            rst,
  input  logic [$clog2(`MEMS_NUM_CH)-1:0] ch_sel,
  input  logic [`MEMS_DATA_W-1:0]         ch_data,
  input  logic                            ch_write,
  input  logic                            commit,
  output logic                            busy,
  output logic                            init_done,
  output logic                            sck,
  output logic                            mosi,
  output logic                            cs_n
);

  spi_frame_if frame_link ();

  // init, shadow registers and burst ordering
  dac_frame_seq i_dac_frame_seq (
    .clk       (clk),
    .rst       (rst),
    .ch_sel    (ch_sel),
    .ch_data   (ch_data),
    .ch_write  (ch_write),
    .commit    (commit),
    .busy      (busy),
    .init_done (init_done),
    .link      (frame_link.master)
  );

  // 24-bit frame engine
  mems_spi_tx i_mems_spi_tx (
    .clk  (clk),
    .rst  (rst),
    .link (frame_link.slave),
    .sck  (sck),
    .mosi (mosi),
    .cs_n (cs_n)
  );

endmodule

/* sim/spi_frame_capture.sv */
`timescale 1ns/1ps

`include "mems_defs.svh"

// rebuilds dac frames from the spi pins
module spi_frame_capture (
  input logic sck,
  input logic mosi,
  input logic cs_n
);

  localparam int frame_w = `MEMS_FRAME_W;

  logic [frame_w-1:0] shift;
  logic [frame_w-1:0] frames [$];  // completed frames, oldest first
  int                 bit_cnt;
  int                 err_count;
  bit                 in_frame;

  initial begin
    shift     = '0;
    bit_cnt   = 0;
    err_count = 0;
    in_frame  = 1'b0;
  end

  // frame opens on a real 1 to 0 edge only
  always @(negedge cs_n) begin
    if (cs_n === 1'b0) begin
      in_frame = 1'b1;
      bit_cnt  = 0;
      shift    = '0;
    end
  end

  // dac samples on the falling sck edge, msb first
  always @(negedge sck) begin
    if (in_frame && cs_n === 1'b0) begin
      shift   = {shift[frame_w-2:0], mosi};
      bit_cnt = bit_cnt + 1;
    end
  end

  always @(posedge cs_n) begin
    if (in_frame) begin
      in_frame = 1'b0;
      assert (bit_cnt == frame_w) else begin
        $display("frame closed at %0t with %0d bits instead of %0d", $time, bit_cnt, frame_w);
        err_count = err_count + 1;
      end
      frames.push_back(shift);
    end
  end

endmodule

/* sim/mems_dac_tb.sv */
`timescale 1ns/1ps

`include "mems_defs.svh"

module mems_dac_tb import dac_pkg::*;;

  localparam int num_ch       = `MEMS_NUM_CH;
  localparam int reset_cycles = 8;
  localparam int frame_cycles = 2 + (`MEMS_CLK_DIV * 51) / 2;  // start to new_data
  // init 2, single 2, multi 5, empty 1, busy 3 + 1, random 40 x 5 at most
  localparam int max_frames   = 2 + 2 + 5 + 1 + 4 + 40 * 5;
  localparam int cycle_limit  = (max_frames * frame_cycles * 3) / 2 + reset_cycles;

  logic        clk;
  logic        rst;
  logic [1:0]  ch_sel;
  logic [15:0] ch_data;
  logic        ch_write;
  logic        commit;
  logic        busy;
  logic        init_done;
  logic        sck;
  logic        mosi;
  logic        cs_n;

  integer      seed;
  int          cycle_cnt;
  int          err_count;
  int          tests_run;
  int          tests_failed;
  int          errs_at_start;
  logic [15:0] model_shadow [num_ch];
  bit          model_dirty  [num_ch];
  logic [23:0] exp_q [$];  // predicted frames, oldest first

  mems_dac_top i_mems_dac_top (
    .clk       (clk),
    .rst       (rst),
    .ch_sel    (ch_sel),
    .ch_data   (ch_data),
    .ch_write  (ch_write),
    .commit    (commit),
    .busy      (busy),
    .init_done (init_done),
    .sck       (sck),
    .mosi      (mosi),
    .cs_n      (cs_n)
  );

  spi_frame_capture i_spi_frame_capture (
    .sck  (sck),
    .mosi (mosi),
    .cs_n (cs_n)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < cycle_limit) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("run stopped after %0d cycles before the tests finished", cycle_cnt);
    $display("Simulation failed");
    $finish;
  end

  function automatic logic [23:0] build_frame(dac_cmd_t cmd, logic [2:0] addr,
                                              logic [15:0] data);
    return {2'b00, cmd, addr, data};
  endfunction

  function automatic int error_total();
    return err_count + i_spi_frame_capture.err_count;
  endfunction

  task automatic write_ch(input int ch, input logic [15:0] data);
    @(negedge clk);
    ch_sel   = ch[1:0];
    ch_data  = data;
    ch_write = 1'b1;
    @(negedge clk);
    ch_write = 1'b0;
    model_shadow[ch] = data;
    model_dirty[ch]  = 1'b1;
  endtask

  // dirty channels ascending, then update-all
  task automatic predict_burst();
    for (int i = 0; i < num_ch; i++) begin
      if (model_dirty[i]) begin
        exp_q.push_back(build_frame(cmd_write_input, 3'(i), model_shadow[i]));
        model_dirty[i] = 1'b0;
      end
    end
    exp_q.push_back(build_frame(cmd_update_all, 3'd7, 16'h0000));
  endtask

  task automatic pulse_commit();
    @(negedge clk);
    commit = 1'b1;
    @(negedge clk);
    commit = 1'b0;
  endtask

  task automatic wait_idle();
    while (busy) @(negedge clk);
    assert (cs_n === 1'b1) else begin
      $display("ERR %0t: cs_n still low after the DUT went idle", $time);
      err_count++;
    end
  endtask

  task automatic check_frames();
    logic [23:0] exp;
    logic [23:0] got;
    while (exp_q.size() > 0) begin
      exp = exp_q.pop_front();
      assert (i_spi_frame_capture.frames.size() > 0) else begin
        $display("frame %h was expected but never appeared on the bus", exp);
        err_count++;
      end
      if (i_spi_frame_capture.frames.size() > 0) begin
        got = i_spi_frame_capture.frames.pop_front();
        assert (got === exp) else begin
          $display("ERR %0t: expected frame %h, got %h", $time, exp, got);
          err_count++;
        end
      end
    end
    assert (i_spi_frame_capture.frames.size() == 0) else begin
      $display("%0d frames appeared on the bus that were not expected",
               i_spi_frame_capture.frames.size());
      err_count++;
      i_spi_frame_capture.frames.delete();
    end
  endtask

  task automatic end_test(input string name);
    int errs;
    errs = error_total() - errs_at_start;
    tests_run++;
    if (errs != 0) tests_failed++;
    $display("test %-16s %s (%0d errors)", name, (errs == 0) ? "ok" : "FAILED", errs);
    errs_at_start = error_total();
  endtask

  initial begin
    int          order [4];
    int          j;
    int          tmp;
    int          n_wr;
    logic [15:0] data;

    seed          = 32982;
    err_count     = 0;
    tests_run     = 0;
    tests_failed  = 0;
    errs_at_start = 0;
    rst      = 1'b1;
    ch_sel   = '0;
    ch_data  = '0;
    ch_write = 1'b0;
    commit   = 1'b0;
    for (int i = 0; i < num_ch; i++) begin
      model_shadow[i] = '0;
      model_dirty[i]  = 1'b0;
    end

    repeat (reset_cycles) @(posedge clk);
    @(negedge clk);
    assert (!busy && !init_done && cs_n === 1'b1) else begin
      $display("ERR %0t: wrong level in reset, busy %b init_done %b cs_n %b",
               $time, busy, init_done, cs_n);
      err_count++;
    end
    rst = 1'b0;

    // test 1, init frames
    exp_q.push_back(build_frame(cmd_sw_reset, 3'd0, 16'h0000));
    exp_q.push_back(build_frame(cmd_int_ref, 3'd0, 16'h0001));
    while (!init_done) @(negedge clk);
    wait_idle();
    check_frames();
    end_test("init");

    // test 2, one channel
    data = $random(seed);
    write_ch($unsigned($random(seed)) % num_ch, data);
    pulse_commit();
    predict_burst();
    wait_idle();
    check_frames();
    end_test("single_channel");

    // test 3, shuffled writes plus one repeat
    for (int i = 0; i < 4; i++) order[i] = i;
    for (int i = 3; i > 0; i--) begin
      j        = $unsigned($random(seed)) % (i + 1);
      tmp      = order[i];
      order[i] = order[j];
      order[j] = tmp;
    end
    for (int i = 0; i < 5; i++) begin
      data = $random(seed);
      write_ch(order[i % 4], data);
    end
    pulse_commit();
    predict_burst();
    wait_idle();
    check_frames();
    end_test("multi_channel");

    // test 4, nothing dirty
    pulse_commit();
    predict_burst();
    wait_idle();
    check_frames();
    end_test("empty_commit");

    // test 5, commits merge while a burst runs
    data = $random(seed);
    write_ch(1, data);
    data = $random(seed);
    write_ch(3, data);
    pulse_commit();
    predict_burst();
    for (int k = 0; k < 3; k++) begin
      repeat (10 + $unsigned($random(seed)) % 50) @(negedge clk);
      assert (busy) else begin
        $display("ERR %0t: busy fell before the extra commit was issued", $time);
        err_count++;
      end
      pulse_commit();
    end
    predict_burst();  // merged commit, update-all only
    wait_idle();
    check_frames();
    end_test("commit_busy");

    // test 6, random rounds
    for (int r = 0; r < 40; r++) begin
      n_wr = $unsigned($random(seed)) % 5;
      for (int w = 0; w < n_wr; w++) begin
        repeat ($unsigned($random(seed)) % 4) @(negedge clk);
        data = $random(seed);
        write_ch($unsigned($random(seed)) % num_ch, data);
      end
      if (($unsigned($random(seed)) % 4 != 0) || (r == 39)) begin
        pulse_commit();
        predict_burst();
        wait_idle();
        check_frames();
      end
    end
    end_test("random_run");

    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, error_total());
    if (tests_failed == 0 && error_total() == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* filelist.f */
+incdir+src
src/spi_pkg.sv
src/dac_pkg.sv
src/spi_frame_if.sv
src/mems_spi_tx.sv
src/dac_frame_seq.sv
src/mems_dac_top.sv
sim/spi_frame_capture.sv
sim/mems_dac_tb.sv
